//--- lsq_cfg.svh
// load/store queue configuration
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// queue geometry
`define LSQ_DEPTH   16   // entries, power of two
`define LSQ_ID_W    4    // log2 of depth

// datapath
`define LSQ_DATA_W  32   // address and data width
`define LSQ_WB_W    4    // writeback register tag

// data memory model
`define MEM_WORDS   1024 // word count
`define MEM_IDX_LO  2    // byte offset bits below word index
`define MEM_LATENCY 2    // request to response, in cycles

`endif

//--- lsq_pkg.sv
// load/store queue types
package lsq_pkg;

`include "lsq_cfg.svh"

  // queue slot index, also the memory request id
  typedef logic [`LSQ_ID_W-1:0] lsq_id_t;

  // address or data word
  typedef logic [`LSQ_DATA_W-1:0] word_t;

  // destination register tag, carried back to the core
  typedef logic [`LSQ_WB_W-1:0] wb_tag_t;

  // one queue slot
  typedef struct packed {
    logic    valid;  // slot holds a live op
    logic    rw;     // 1 = store
    logic    done;   // data final, ready to retire
    word_t   addr;
    word_t   data;   // store data or load result
    wb_tag_t wb;
  } lsq_entry_t;

endpackage

//--- lsq_if.sv
// queue to memory and queue to retire interfaces
`timescale 1ns/1ps

// single-cycle request, fixed latency response
interface lsq_mem_if;
  import lsq_pkg::*;

  logic    req_valid;
  logic    req_rw;     // 1 = write
  lsq_id_t req_id;
  word_t   req_addr;
  word_t   req_data;

  logic    resp_valid;
  lsq_id_t resp_id;    // echoes req_id
  word_t   resp_data;  // zero for stores

  modport lsq (
    output req_valid, req_rw, req_id, req_addr, req_data,
    input  resp_valid, resp_id, resp_data
  );

  modport mem (
    input  req_valid, req_rw, req_id, req_addr, req_data,
    output resp_valid, resp_id, resp_data
  );
endinterface

// oldest slot view plus pop back to the queue
interface lsq_head_if;
  import lsq_pkg::*;

  logic    head_valid;
  logic    head_done;
  logic    head_rw;
  word_t   head_data;
  wb_tag_t head_wb;
  logic    pop;        // frees the head slot on this edge

  modport buffer (output head_valid, head_done, head_rw, head_data, head_wb, input pop);
  modport retire (input head_valid, head_done, head_rw, head_data, head_wb, output pop);
endinterface

//--- lsq_buffer.sv
// load/store queue storage and issue
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module lsq_buffer (
  input  logic             clk,
  input  logic             rst,
  input  logic             op_valid,
  input  logic             op_rw,    // 1 = store
  input  lsq_pkg::word_t   op_addr,
  input  lsq_pkg::word_t   op_data,
  input  lsq_pkg::wb_tag_t op_wb,
  output logic             full,
  lsq_mem_if.lsq           mem,
  lsq_head_if.buffer       head
);
  import lsq_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS); // word index bits seen by memory
  localparam int CNT_W = `LSQ_ID_W + 1;      // count reaches depth

  typedef logic [CNT_W-1:0] cnt_t;

  lsq_entry_t q [`LSQ_DEPTH];
  lsq_id_t    head_ptr;  // oldest slot
  lsq_id_t    tail_ptr;  // next free slot
  cnt_t       count;

  logic  accept;
  logic  issue;          // op needs a memory access
  logic  fwd_hit;
  word_t fwd_data;

  // memory sees only these address bits
  function automatic logic [IDX_W-1:0] word_idx(word_t a);
    return a[`MEM_IDX_LO +: IDX_W];
  endfunction

  assign full   = (count == cnt_t'(`LSQ_DEPTH));
  assign accept = op_valid && !full;

  // store-to-load search, oldest to youngest so the youngest match wins
  always_comb begin
    lsq_id_t idx;
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      idx = head_ptr + lsq_id_t'(k); // wraps at depth
      if (q[idx].valid && q[idx].rw && word_idx(q[idx].addr) == word_idx(op_addr)) begin
        fwd_hit  = 1'b1;
        fwd_data = q[idx].data;
      end
    end
  end

  assign issue = accept && (op_rw || !fwd_hit); // stores always go to memory

  // slot state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
        q[i].valid <= 1'b0;
        q[i].done  <= 1'b0;
      end
    end else begin
      if (accept) begin
        q[tail_ptr].valid <= 1'b1;
        q[tail_ptr].rw    <= op_rw;
        q[tail_ptr].done  <= !op_rw && fwd_hit;  // forwarded load finishes now
        q[tail_ptr].addr  <= op_addr;
        q[tail_ptr].data  <= (!op_rw && fwd_hit) ? fwd_data : op_data;
        q[tail_ptr].wb    <= op_wb;
      end
      if (mem.resp_valid) begin
        q[mem.resp_id].done <= 1'b1;
        if (!q[mem.resp_id].rw) begin
          q[mem.resp_id].data <= mem.resp_data; // stores keep own data
        end
      end
      if (head.pop) begin
        q[head_ptr].valid <= 1'b0;
        q[head_ptr].done  <= 1'b0;
      end
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (accept) tail_ptr <= tail_ptr + lsq_id_t'(1);
      if (head.pop) head_ptr <= head_ptr + lsq_id_t'(1);
      case ({accept, head.pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;            // both or neither
      endcase
    end
  end

  // memory request, one cycle after accept
  always_ff @(posedge clk) begin
    if (rst) begin
      mem.req_valid <= 1'b0;
    end else begin
      mem.req_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      mem.req_rw   <= op_rw;
      mem.req_id   <= tail_ptr;  // slot id travels with the request
      mem.req_addr <= op_addr;
      mem.req_data <= op_data;
    end
  end

  // head view for retire
  assign head.head_valid = q[head_ptr].valid;
  assign head.head_done  = q[head_ptr].done;
  assign head.head_rw    = q[head_ptr].rw;
  assign head.head_data  = q[head_ptr].data;
  assign head.head_wb    = q[head_ptr].wb;

  // pointer bookkeeping keeps the tail slot free whenever not full
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    accept |-> !q[tail_ptr].valid);

  // memory answers only outstanding slots
  a_resp_live: assert property (@(posedge clk) disable iff (rst)
    mem.resp_valid |-> q[mem.resp_id].valid && !q[mem.resp_id].done);

endmodule

//--- lsq_retire.sv
// in-order retire output register
`timescale 1ns/1ps

module lsq_retire (
  input  logic             clk,
  input  logic             rst,
  input  logic             result_ready,
  lsq_head_if.retire       head,
  output logic             result_valid,
  output logic             result_rw,
  output lsq_pkg::word_t   result_data,
  output lsq_pkg::wb_tag_t result_wb
);

  logic load;

  // take head when slot empty or draining this cycle
  assign load     = head.head_valid && head.head_done && (!result_valid || result_ready);
  assign head.pop = load;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else if (load) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;  // consumed, nothing behind it
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (load) begin
      result_rw   <= head.head_rw;
      result_data <= head.head_data;
      result_wb   <= head.head_wb;
    end
  end

  // held steady while the core stalls
  a_result_stable: assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=> result_valid && $stable(result_rw)
      && $stable(result_data) && $stable(result_wb));

endmodule

//--- dcache_model.sv
// fixed latency data memory model
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module dcache_model (
  input logic    clk,
  input logic    rst,
  lsq_mem_if.mem mem
);
  import lsq_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int LAT   = `MEM_LATENCY;

  word_t            mem_q [`MEM_WORDS];
  logic [IDX_W-1:0] idx;

  logic    pipe_valid [LAT];  // response delay line
  lsq_id_t pipe_id    [LAT];
  word_t   pipe_data  [LAT];

  assign idx = mem.req_addr[`MEM_IDX_LO +: IDX_W];

  // word array, preset to its own index
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_q[i] <= word_t'(i);
      end
    end else if (mem.req_valid && mem.req_rw) begin
      mem_q[idx] <= mem.req_data;  // write on request edge
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < LAT; s++) begin
        pipe_valid[s] <= 1'b0;
      end
    end else begin
      pipe_valid[0] <= mem.req_valid;
      for (int s = 1; s < LAT; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  // id and data ride alongside
  always_ff @(posedge clk) begin
    pipe_id[0]   <= mem.req_id;
    pipe_data[0] <= mem.req_rw ? '0 : mem_q[idx]; // read before this edge's write
    for (int s = 1; s < LAT; s++) begin
      pipe_id[s]   <= pipe_id[s-1];
      pipe_data[s] <= pipe_data[s-1];
    end
  end

  assign mem.resp_valid = pipe_valid[LAT-1];
  assign mem.resp_id    = pipe_id[LAT-1];
  assign mem.resp_data  = pipe_data[LAT-1];

  // every response matches a request taken exactly LAT cycles back
  a_resp_timing: assert property (@(posedge clk) disable iff (rst)
    mem.resp_valid |-> $past(mem.req_valid, LAT) && mem.resp_id == $past(mem.req_id, LAT));

endmodule

//--- lsq_top.sv
// load/store queue with data memory
`timescale 1ns/1ps

module lsq_top (
  input  logic             clk,
  input  logic             rst,
  // core issue side
  input  logic             op_valid,
  input  logic             op_rw,
  input  lsq_pkg::word_t   op_addr,
  input  lsq_pkg::word_t   op_data,
  input  lsq_pkg::wb_tag_t op_wb,
  output logic             full,
  // core retire side
  input  logic             result_ready,
  output logic             result_valid,
  output logic             result_rw,
  output lsq_pkg::word_t   result_data,
  output lsq_pkg::wb_tag_t result_wb
);

  lsq_mem_if  mem_if ();   // queue <-> memory
  lsq_head_if head_if ();  // queue <-> retire

  lsq_buffer u_buffer (
    .clk      (clk),
    .rst      (rst),
    .op_valid (op_valid),
    .op_rw    (op_rw),
    .op_addr  (op_addr),
    .op_data  (op_data),
    .op_wb    (op_wb),
    .full     (full),
    .mem      (mem_if.lsq),
    .head     (head_if.buffer)
  );

  dcache_model u_dcache (
    .clk (clk),
    .rst (rst),
    .mem (mem_if.mem)
  );

  lsq_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .result_ready (result_ready),
    .head         (head_if.retire),
    .result_valid (result_valid),
    .result_rw    (result_rw),
    .result_data  (result_data),
    .result_wb    (result_wb)
  );

endmodule

//--- tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);  // seen high on ten rising edges
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- tb_checker.sv
// result checker and reference model
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module tb_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             op_valid,
  input  logic             op_rw,
  input  lsq_pkg::word_t   op_addr,
  input  lsq_pkg::word_t   op_data,
  input  lsq_pkg::wb_tag_t op_wb,
  input  logic             full,
  input  logic             result_ready,
  input  logic             result_valid,
  input  logic             result_rw,
  input  lsq_pkg::word_t   result_data,
  input  lsq_pkg::wb_tag_t result_wb,
  output int               errors,
  output int               pending    // results still owed
);
  import lsq_pkg::*;

  word_t      model [`MEM_WORDS];  // memory as program order sees it
  lsq_entry_t expect_q [$];        // rw, data, wb per accepted op
  lsq_entry_t held;                // result shown on a stalled edge
  logic       stalled = 1'b0;
  int         accepts = 0;
  int         delivered = 0;
  int         t_errors = 0;        // per test
  int         t_ops = 0;
  int         t_results = 0;
  int         n_pass = 0;
  int         n_fail = 0;

  initial begin
    errors  = 0;
    pending = 0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model[i] = word_t'(i);  // word holds its own index
    end
  end

  task automatic show_mismatch(input string sig, input word_t got, input word_t exp);
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
    errors++;
    t_errors++;
  endtask

  task automatic log_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
    t_errors++;
  endtask

  always @(posedge clk) begin
    lsq_entry_t ent;
    logic       exp_full;
    int         idx;
    if (!rst) begin
      // held entries = accepted minus popped, output register not counted
      exp_full = (accepts - delivered - int'(result_valid)) == `LSQ_DEPTH;
      if (full !== exp_full) show_mismatch("full", word_t'(full), word_t'(exp_full));
      if (stalled && (result_valid !== 1'b1 || result_rw !== held.rw
          || result_data !== held.data || result_wb !== held.wb)) begin
        log_failure("result changed while result_ready was low");
      end
      if (result_valid !== 1'b0 && expect_q.size() == 0) begin
        log_failure("result_valid not low with no operation outstanding");
      end else if (result_valid && result_ready) begin
        ent = expect_q.pop_front();  // oldest owed result
        if (result_rw !== ent.rw) show_mismatch("result_rw", word_t'(result_rw), word_t'(ent.rw));
        if (result_data !== ent.data) show_mismatch("result_data", result_data, ent.data);
        if (result_wb !== ent.wb) show_mismatch("result_wb", word_t'(result_wb), word_t'(ent.wb));
        delivered++;
        t_results++;
      end
      if (op_valid && !full) begin  // accept edge
        idx = int'(op_addr[`MEM_IDX_LO +: $clog2(`MEM_WORDS)]);
        if (op_rw) model[idx] = op_data;  // store returns own data
        ent      = '0;
        ent.rw   = op_rw;
        ent.data = model[idx];
        ent.wb   = op_wb;
        expect_q.push_back(ent);
        accepts++;
        t_ops++;
      end
      stalled   = result_valid && !result_ready;
      held.rw   = result_rw;
      held.data = result_data;
      held.wb   = result_wb;
      pending   = expect_q.size();
    end
  end

  task automatic close_test(input string name);
    if (t_results != t_ops) begin
      log_failure($sformatf("%0d results for %0d accepted operations", t_results, t_ops));
    end
    if (t_errors == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %s: %s, %0d operations, %0d errors", name,
             (t_errors == 0) ? "passed" : "failed", t_ops, t_errors);
    t_errors  = 0;
    t_ops     = 0;
    t_results = 0;
  endtask

  task automatic print_totals();
    $display("tests passed %0d, tests failed %0d, check errors %0d", n_pass, n_fail, errors);
  endtask

endmodule

//--- tb_top.sv
// load/store queue testbench
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module tb_top;
  import lsq_pkg::*;

  localparam int N_LOAD   = 24;
  localparam int N_PAIR   = 8;   // store then load, same word
  localparam int N_MIX    = 48;
  localparam int N_STALL  = 24;  // more than depth so full rises
  localparam int N_TOGGLE = 48;
  localparam int N_OPS    = N_LOAD + 2 * N_PAIR + N_MIX + N_STALL + N_TOGGLE;
  localparam int MAX_CYCLES = N_OPS * (`LSQ_DEPTH + `MEM_LATENCY + 4);
  localparam int DRAIN_CYCLES = `LSQ_DEPTH * (`LSQ_DEPTH + `MEM_LATENCY + 4); // full queue empties

  logic        clk;
  logic        rst;
  logic        op_valid;
  logic        op_rw;
  word_t       op_addr;
  word_t       op_data;
  wb_tag_t     op_wb;
  logic        full;
  logic        result_ready;
  logic        result_valid;
  logic        result_rw;
  word_t       result_data;
  wb_tag_t     result_wb;
  int          errors;
  int          pending;
  int          cycles;
  logic [15:0] lfsr;
  logic        stim_done;
  word_t       pair_addr;

  tb_clock u_clock (.clk(clk), .rst(rst));

  lsq_top i_dut (
    .clk(clk), .rst(rst), .op_valid(op_valid), .op_rw(op_rw), .op_addr(op_addr),
    .op_data(op_data), .op_wb(op_wb), .full(full), .result_ready(result_ready),
    .result_valid(result_valid), .result_rw(result_rw), .result_data(result_data),
    .result_wb(result_wb)
  );

  tb_checker u_checker (
    .clk(clk), .rst(rst), .op_valid(op_valid), .op_rw(op_rw), .op_addr(op_addr),
    .op_data(op_data), .op_wb(op_wb), .full(full), .result_ready(result_ready),
    .result_valid(result_valid), .result_rw(result_rw), .result_data(result_data),
    .result_wb(result_wb), .errors(errors), .pending(pending)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic word_t take_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic word_t rand_addr();
    return take_bits(3) << `MEM_IDX_LO;  // 8 words, frequent repeats
  endfunction

  // drive on falling edge, hold until full is low for the next rise
  task automatic issue_op(input logic rw, input word_t a, input word_t d, input wb_tag_t wb);
    @(negedge clk);
    op_valid = 1'b1;
    op_rw    = rw;
    op_addr  = a;
    op_data  = d;
    op_wb    = wb;
    while (full) @(negedge clk);
  endtask

  task automatic random_op(input logic stores);
    logic rw;
    rw = stores && (take_bits(1) != '0);
    issue_op(rw, rand_addr(), take_bits(32), wb_tag_t'(take_bits(4)));
  endtask

  task automatic end_stream();
    @(negedge clk);  // past the last accept edge
    op_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    end_stream();
    while (pending != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    repeat (4) @(negedge clk);  // idle tail, catches stray results
  endtask

  // cycle budget for the whole run
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    op_valid     = 1'b0;
    op_rw        = 1'b0;
    op_addr      = '0;
    op_data      = '0;
    op_wb        = '0;
    result_ready = 1'b1;
    lfsr         = 16'd16382;
    stim_done    = 1'b0;
    wait (rst === 1'b0);
    repeat (5) @(negedge clk);  // nothing issued, outputs must stay low
    u_checker.close_test("reset idle");
    for (int i = 0; i < N_LOAD; i++) random_op(1'b0);
    drain();
    u_checker.close_test("random loads");
    for (int i = 0; i < N_PAIR; i++) begin
      pair_addr = rand_addr();
      issue_op(1'b1, pair_addr, take_bits(32), wb_tag_t'(take_bits(4)));
      issue_op(1'b0, pair_addr, take_bits(32), wb_tag_t'(take_bits(4)));  // forwarded
    end
    drain();
    u_checker.close_test("store to load forwarding");
    for (int i = 0; i < N_MIX; i++) random_op(1'b1);
    drain();
    u_checker.close_test("random mix");
    result_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < N_STALL; i++) random_op(1'b1);
        end_stream();
      end
      begin
        wait (full === 1'b1);
        repeat (6) @(negedge clk);  // op held while full
        result_ready = 1'b1;
      end
    join
    drain();
    u_checker.close_test("full back-pressure");
    fork
      begin
        for (int i = 0; i < N_TOGGLE; i++) random_op(1'b1);
        end_stream();
        stim_done = 1'b1;
      end
      while (!stim_done) begin
        @(negedge clk);
        result_ready = (take_bits(1) != '0);
      end
    join
    result_ready = 1'b1;
    drain();
    u_checker.close_test("random result_ready");
    u_checker.print_totals();
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
lsq_pkg.sv
lsq_if.sv
lsq_buffer.sv
lsq_retire.sv
dcache_model.sv
lsq_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv
